// File: Bender.yml
package:
  name: mipsPipeline

sources:
  - rtl/mipsPkg.sv
  - rtl/pipeIfs.sv
  - rtl/fetchStage.sv
  - rtl/regFile.sv
  - rtl/decodeStage.sv
  - rtl/hazardUnit.sv
  - rtl/executeStage.sv
  - rtl/memoryStage.sv
  - rtl/mipsPipeline.sv
  - target: test
    files:
      - verif/tbMipsPipeline.sv

// File: mipsPipeline.f
rtl/mipsPkg.sv
rtl/pipeIfs.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsPipeline.sv
verif/tbMipsPipeline.sv

// File: rtl/decodeStage.sv
module decodeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  logic     loadStall,
    input  logic     flushIdEx,
    input  word_t    instr,
    input  word_t    pcPlus4,
    input  logic     wbRegWrite,
    input  regAddr_t wbSel,
    input  word_t    wbData,
    output regAddr_t rs,
    output regAddr_t rt,
    output logic     jumpTaken,
    output word_t    jumpTarget,
    idExIf.source    idEx
);

    opcode_e  opcode;
    funct_e   funct;
    regAddr_t rd;
    regAddr_t writeSel;
    word_t    imm;
    word_t    branchTarget;
    word_t    readA;
    word_t    readB;
    logic     regWrite;
    logic     memToReg;
    logic     memWrite;
    logic     branch;
    logic     aluSrcImm;
    aluOp_e   aluOp;

    assign opcode = opcode_e'(instr[opMsb:opLsb]);
    assign funct  = funct_e'(instr[functMsb:functLsb]);
    assign rs     = instr[rsMsb:rsLsb];
    assign rt     = instr[rtMsb:rtLsb];
    assign rd     = instr[rdMsb:rdLsb];

    assign imm          = {{(dataWidth - immMsb - 1){instr[immMsb]}}, instr[immMsb:immLsb]};
    assign branchTarget = pcPlus4 + {imm[dataWidth-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[dataWidth-1 -: 4], instr[targetMsb:targetLsb], 2'b00};
    assign writeSel     = (opcode == opRType) ? rd : rt;

    //////////////////////////////////////////////////
    // main control
    //////////////////////////////////////////////////

    always_comb begin
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        aluSrcImm = 1'b0;
        jumpTaken = 1'b0;
        aluOp     = aluAdd;
        case (opcode)
            opRType: begin
                // unknown function codes (nop included) write nothing
                regWrite = 1'b1;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opLw: begin
                regWrite  = 1'b1;
                memToReg  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opSw: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opBeq: begin
                branch = 1'b1;
                aluOp  = aluSub;
            end
            opJ:     jumpTaken = 1'b1;
            default: ;
        endcase
    end

    regFile regFile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rdAddrA (rs),
        .rdAddrB (rt),
        .rdDataA (readA),
        .rdDataB (readB),
        .wrEn    (wbRegWrite),
        .wrAddr  (wbSel),
        .wrData  (wbData)
    );

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || (!freeze && (flushIdEx || loadStall))) begin
            // bubble or reset state
            idEx.regWrite     <= 1'b0;
            idEx.memToReg     <= 1'b0;
            idEx.memWrite     <= 1'b0;
            idEx.branch       <= 1'b0;
            idEx.aluSrcImm    <= 1'b0;
            idEx.aluOp        <= aluAdd;
            idEx.readA        <= '0;
            idEx.readB        <= '0;
            idEx.imm          <= '0;
            idEx.branchTarget <= '0;
            idEx.rs           <= '0;
            idEx.rt           <= '0;
            idEx.writeSel     <= '0;
        end else if (!freeze) begin
            idEx.regWrite     <= regWrite;
            idEx.memToReg     <= memToReg;
            idEx.memWrite     <= memWrite;
            idEx.branch       <= branch;
            idEx.aluSrcImm    <= aluSrcImm;
            idEx.aluOp        <= aluOp;
            idEx.readA        <= readA;
            idEx.readB        <= readB;
            idEx.imm          <= imm;
            idEx.branchTarget <= branchTarget;
            idEx.rs           <= rs;
            idEx.rt           <= rt;
            idEx.writeSel     <= writeSel;
        end
    end

endmodule

// File: rtl/executeStage.sv
module executeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  logic     flushExMem,
    idExIf.sink      idEx,
    input  logic     wbRegWrite,
    input  regAddr_t wbSel,
    input  word_t    wbData,
    exMemIf.source   exMem
);

    word_t opA;
    word_t opB;
    word_t aluB;
    word_t aluResult;
    logic  zero;

    //////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////

    // newest producer wins, r0 is never forwarded
    function automatic word_t forwardOp(regAddr_t src, word_t regVal);
        if (src == '0) begin
            return regVal;
        end
        if (exMem.regWrite && exMem.writeSel == src) begin
            return exMem.aluOut;
        end
        if (wbRegWrite && wbSel == src) begin
            return wbData;
        end
        return regVal;
    endfunction

    always_comb begin
        opA = forwardOp(idEx.rs, idEx.readA);
        opB = forwardOp(idEx.rt, idEx.readB);
    end

    assign aluB = idEx.aluSrcImm ? idEx.imm : opB;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluResult = opA + aluB;
        endcase
    end

    assign zero = (aluResult == '0);

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || (!freeze && flushExMem)) begin
            exMem.regWrite     <= 1'b0;
            exMem.memToReg     <= 1'b0;
            exMem.memWrite     <= 1'b0;
            exMem.branch       <= 1'b0;
            exMem.zero         <= 1'b0;
            exMem.aluOut       <= '0;
            exMem.storeData    <= '0;
            exMem.branchTarget <= '0;
            exMem.writeSel     <= '0;
        end else if (!freeze) begin
            exMem.regWrite     <= idEx.regWrite;
            exMem.memToReg     <= idEx.memToReg;
            exMem.memWrite     <= idEx.memWrite;
            exMem.branch       <= idEx.branch;
            exMem.zero         <= zero;
            exMem.aluOut       <= aluResult;
            exMem.storeData    <= opB;
            exMem.branchTarget <= idEx.branchTarget;
            exMem.writeSel     <= idEx.writeSel;
        end
    end

endmodule

// File: rtl/fetchStage.sv
module fetchStage import mipsPkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  freeze,
    input  logic  loadStall,
    input  logic  flushIfId,
    input  logic  branchTaken,
    input  logic  jumpTaken,
    input  word_t branchTarget,
    input  word_t jumpTarget,
    input  word_t icacheRdata,
    output word_t pc,
    output word_t instr,
    output word_t pcPlus4
);

    word_t pcInc;
    word_t pcNext;

    assign pcInc = pc + pcStep;

    // branch from MEM beats everything, a stall beats the jump from decode
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (loadStall) begin
            pcNext = pc;
        end else if (jumpTaken) begin
            pcNext = jumpTarget;
        end else begin
            pcNext = pcInc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!freeze) begin
            pc <= pcNext;
        end
    end

    //////////////////////////////////////////////////
    // IF/ID register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr   <= '0;
            pcPlus4 <= '0;
        end else if (!freeze && !loadStall) begin
            if (flushIfId) begin
                instr   <= '0;
                pcPlus4 <= '0;
            end else begin
                instr   <= icacheRdata;
                pcPlus4 <= pcInc;
            end
        end
    end

endmodule

// File: rtl/hazardUnit.sv
module hazardUnit import mipsPkg::*; (
    input  logic     icacheStall,
    input  logic     dcacheStall,
    input  regAddr_t rs,
    input  regAddr_t rt,
    idExIf.peek      idEx,
    input  logic     branchTaken,
    input  logic     jumpTaken,
    output logic     freeze,
    output logic     loadStall,
    output logic     flushIfId,
    output logic     flushIdEx,
    output logic     flushExMem
);

    logic loadUse;

    // either cache stalling freezes the whole pipe
    assign freeze = icacheStall | dcacheStall;

    assign loadUse = idEx.memToReg && idEx.rt != '0
                     && (idEx.rt == rs || idEx.rt == rt);

    // a taken branch squashes the dependent instruction anyway
    assign loadStall = loadUse & ~branchTaken;

    // a jump held by a stall must stay in IF/ID
    assign flushIfId  = branchTaken | (jumpTaken & ~loadStall);
    assign flushIdEx  = branchTaken;
    assign flushExMem = branchTaken;

endmodule

// File: rtl/memoryStage.sv
module memoryStage import mipsPkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     freeze,
    exMemIf.sink                     exMem,
    output logic                     dcacheRen,
    output logic                     dcacheWen,
    output logic [wordAddrWidth-1:0] dcacheAddr,
    output word_t                    dcacheWdata,
    input  word_t                    dcacheRdata,
    output logic                     branchTaken,
    output word_t                    branchTarget,
    output logic                     wbRegWrite,
    output regAddr_t                 wbSel,
    output word_t                    wbData
);

    logic  wbMemToReg;
    word_t wbLoadData;
    word_t wbAluOut;

    // only a load reads the data cache
    assign dcacheRen   = exMem.memToReg;
    assign dcacheWen   = exMem.memWrite;
    assign dcacheAddr  = exMem.aluOut[dataWidth-1 -: wordAddrWidth];
    assign dcacheWdata = exMem.storeData;

    assign branchTaken  = exMem.branch & exMem.zero;
    assign branchTarget = exMem.branchTarget;

    //////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
            wbSel      <= '0;
            wbLoadData <= '0;
            wbAluOut   <= '0;
        end else if (!freeze) begin
            wbRegWrite <= exMem.regWrite;
            wbMemToReg <= exMem.memToReg;
            wbSel      <= exMem.writeSel;
            wbLoadData <= dcacheRdata;
            wbAluOut   <= exMem.aluOut;
        end
    end

    assign wbData = wbMemToReg ? wbLoadData : wbAluOut;

endmodule

// File: rtl/mipsPipeline.sv
module mipsPipeline import mipsPkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [wordAddrWidth-1:0] icacheAddr,
    input  word_t                    icacheRdata,
    input  logic                     icacheStall,
    output logic                     dcacheRen,
    output logic                     dcacheWen,
    output logic [wordAddrWidth-1:0] dcacheAddr,
    output word_t                    dcacheWdata,
    input  word_t                    dcacheRdata,
    input  logic                     dcacheStall
);

    word_t    pc;
    word_t    instr;
    word_t    pcPlus4;
    regAddr_t rs;
    regAddr_t rt;
    logic     jumpTaken;
    word_t    jumpTarget;
    logic     branchTaken;
    word_t    branchTarget;
    logic     freeze;
    logic     loadStall;
    logic     flushIfId;
    logic     flushIdEx;
    logic     flushExMem;
    logic     wbRegWrite;
    regAddr_t wbSel;
    word_t    wbData;

    idExIf  idEx ();
    exMemIf exMem ();

    assign icacheAddr = pc[dataWidth-1 -: wordAddrWidth];

    fetchStage fetchStage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeze       (freeze),
        .loadStall    (loadStall),
        .flushIfId    (flushIfId),
        .branchTaken  (branchTaken),
        .jumpTaken    (jumpTaken),
        .branchTarget (branchTarget),
        .jumpTarget   (jumpTarget),
        .icacheRdata  (icacheRdata),
        .pc           (pc),
        .instr        (instr),
        .pcPlus4      (pcPlus4)
    );

    decodeStage decodeStage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .freeze     (freeze),
        .loadStall  (loadStall),
        .flushIdEx  (flushIdEx),
        .instr      (instr),
        .pcPlus4    (pcPlus4),
        .wbRegWrite (wbRegWrite),
        .wbSel      (wbSel),
        .wbData     (wbData),
        .rs         (rs),
        .rt         (rt),
        .jumpTaken  (jumpTaken),
        .jumpTarget (jumpTarget),
        .idEx       (idEx.source)
    );

    hazardUnit hazardUnit_i (
        .icacheStall (icacheStall),
        .dcacheStall (dcacheStall),
        .rs          (rs),
        .rt          (rt),
        .idEx        (idEx.peek),
        .branchTaken (branchTaken),
        .jumpTaken   (jumpTaken),
        .freeze      (freeze),
        .loadStall   (loadStall),
        .flushIfId   (flushIfId),
        .flushIdEx   (flushIdEx),
        .flushExMem  (flushExMem)
    );

    executeStage executeStage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .freeze     (freeze),
        .flushExMem (flushExMem),
        .idEx       (idEx.sink),
        .wbRegWrite (wbRegWrite),
        .wbSel      (wbSel),
        .wbData     (wbData),
        .exMem      (exMem.source)
    );

    memoryStage memoryStage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeze       (freeze),
        .exMem        (exMem.sink),
        .dcacheRen    (dcacheRen),
        .dcacheWen    (dcacheWen),
        .dcacheAddr   (dcacheAddr),
        .dcacheWdata  (dcacheWdata),
        .dcacheRdata  (dcacheRdata),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .wbRegWrite   (wbRegWrite),
        .wbSel        (wbSel),
        .wbData       (wbData)
    );

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    // byte address without its two low bits
    localparam int wordAddrWidth = 30;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    typedef enum logic [5:0] {
        opRType = 6'd0,
        opJ     = 6'd2,
        opBeq   = 6'd4,
        opAddi  = 6'd8,
        opLw    = 6'd35,
        opSw    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        fnAdd = 6'd32,
        fnSub = 6'd34,
        fnAnd = 6'd36,
        fnOr  = 6'd37,
        fnSlt = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_e;

    // instruction field positions
    localparam int opMsb     = 31;
    localparam int opLsb     = 26;
    localparam int rsMsb     = 25;
    localparam int rsLsb     = 21;
    localparam int rtMsb     = 20;
    localparam int rtLsb     = 16;
    localparam int rdMsb     = 15;
    localparam int rdLsb     = 11;
    localparam int functMsb  = 5;
    localparam int functLsb  = 0;
    localparam int immMsb    = 15;
    localparam int immLsb    = 0;
    localparam int targetMsb = 25;
    localparam int targetLsb = 0;

    localparam int pcStep = 4;

endpackage

// File: rtl/pipeIfs.sv
// ID/EX register contents
interface idExIf import mipsPkg::*; ();

    logic     regWrite;
    logic     memToReg;
    logic     memWrite;
    logic     branch;
    logic     aluSrcImm;
    aluOp_e   aluOp;
    word_t    readA;
    word_t    readB;
    word_t    imm;
    word_t    branchTarget;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t writeSel;

    modport source (
        output regWrite, memToReg, memWrite, branch, aluSrcImm, aluOp,
        output readA, readB, imm, branchTarget, rs, rt, writeSel
    );

    modport sink (
        input regWrite, memToReg, memWrite, branch, aluSrcImm, aluOp,
        input readA, readB, imm, branchTarget, rs, rt, writeSel
    );

    // load-use detection only needs these two
    modport peek (input memToReg, rt);

endinterface

// EX/MEM register contents
interface exMemIf import mipsPkg::*; ();

    logic     regWrite;
    logic     memToReg;
    logic     memWrite;
    logic     branch;
    logic     zero;
    word_t    aluOut;
    word_t    storeData;
    word_t    branchTarget;
    regAddr_t writeSel;

    modport source (
        output regWrite, memToReg, memWrite, branch,
        output zero, aluOut, storeData, branchTarget, writeSel
    );

    modport sink (
        input regWrite, memToReg, memWrite, branch,
        input zero, aluOut, storeData, branchTarget, writeSel
    );

endinterface

// File: rtl/regFile.sv
module regFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    output word_t    rdDataA,
    output word_t    rdDataB,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [2**regAddrWidth];

    // r0 reads zero, a same-cycle write is passed straight through
    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn && addr == wrAddr) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// File: verif/tbMipsPipeline.sv
module tbMipsPipeline import mipsPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    imemDepth    = 64;
    localparam int    dmemDepth    = 256;
    localparam int    stepLimit    = 1000;
    localparam int    storeTimeout = 3000;
    localparam word_t doneAddr     = 32'h0000_03fc;

    logic                     clk;
    logic                     rst_n;
    logic [wordAddrWidth-1:0] icacheAddr;
    word_t                    icacheRdata;
    logic                     icacheStall;
    logic                     dcacheRen;
    logic                     dcacheWen;
    logic [wordAddrWidth-1:0] dcacheAddr;
    word_t                    dcacheWdata;
    word_t                    dcacheRdata;
    logic                     dcacheStall;

    word_t       imem [imemDepth];
    word_t       dmem [dmemDepth];
    word_t       expAddr [$];
    word_t       expData [$];
    int          storeCount;
    int          errorCount;
    logic        stallOn;
    logic [31:0] rngState;
    int          iBurst;
    int          dBurst;

    mipsPipeline mipsPipeline_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheAddr  (icacheAddr),
        .icacheRdata (icacheRdata),
        .icacheStall (icacheStall),
        .dcacheRen   (dcacheRen),
        .dcacheWen   (dcacheWen),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata),
        .dcacheRdata (dcacheRdata),
        .dcacheStall (dcacheStall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // fill pattern for untouched data words uses every address bit
    function automatic word_t fillWord(logic [wordAddrWidth-1:0] a);
        return {a, 2'b01} ^ {a[13:0], a[29:12]} ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rTypeInstr(funct_e fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        word_t w;
        w = '0;
        w[opMsb:opLsb]       = opRType;
        w[rsMsb:rsLsb]       = rs;
        w[rtMsb:rtLsb]       = rt;
        w[rdMsb:rdLsb]       = rd;
        w[functMsb:functLsb] = fn;
        return w;
    endfunction

    function automatic word_t immInstr(opcode_e op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
        word_t w;
        w = '0;
        w[opMsb:opLsb]   = op;
        w[rsMsb:rsLsb]   = rs;
        w[rtMsb:rtLsb]   = rt;
        w[immMsb:immLsb] = imm;
        return w;
    endfunction

    function automatic word_t jumpInstr(logic [25:0] wordIdx);
        word_t w;
        w = '0;
        w[opMsb:opLsb]         = opJ;
        w[targetMsb:targetLsb] = wordIdx;
        return w;
    endfunction

    task automatic stopOnError(input string reason);
        errorCount++;
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compareValue(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stopOnError($sformatf("FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                                  $time, name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // program and reference model
    //////////////////////////////////////////////////

    task automatic loadProgram();
        for (int i = 0; i < imemDepth; i++) begin
            imem[i] = '0;
        end
        // dependent chain forwarded from both stages
        imem[0]  = immInstr(opAddi, 1, 0, 16'd5);
        imem[1]  = immInstr(opAddi, 2, 1, 16'd7);
        imem[2]  = rTypeInstr(fnAdd, 3, 1, 2);
        imem[3]  = rTypeInstr(fnSub, 4, 3, 1);
        imem[4]  = rTypeInstr(fnOr, 5, 4, 3);
        imem[5]  = rTypeInstr(fnAnd, 6, 5, 2);
        imem[6]  = rTypeInstr(fnSlt, 7, 1, 6);
        imem[7]  = immInstr(opAddi, 10, 0, 16'h0100);
        imem[8]  = immInstr(opSw, 3, 10, 16'd0);
        imem[9]  = immInstr(opSw, 5, 10, 16'd4);
        imem[10] = immInstr(opSw, 6, 10, 16'd8);
        imem[11] = immInstr(opSw, 7, 10, 16'd12);
        imem[12] = immInstr(opAddi, 11, 0, -16'sd3);
        imem[13] = rTypeInstr(fnSlt, 12, 11, 1);
        imem[14] = rTypeInstr(fnSub, 13, 11, 4);
        imem[15] = immInstr(opSw, 13, 10, 16'd16);
        imem[16] = immInstr(opSw, 12, 10, 16'd20);
        // load-use pairs
        imem[17] = immInstr(opLw, 14, 10, 16'd0);
        imem[18] = rTypeInstr(fnAdd, 15, 14, 1);
        imem[19] = immInstr(opSw, 15, 10, 16'd24);
        imem[20] = immInstr(opLw, 16, 10, 16'd4);
        imem[21] = immInstr(opSw, 16, 10, 16'd28);
        imem[22] = immInstr(opLw, 17, 0, 16'h0200);
        imem[23] = immInstr(opSw, 17, 10, 16'd32);
        // backward loop of three passes
        imem[24] = immInstr(opAddi, 19, 0, 16'd3);
        imem[25] = immInstr(opAddi, 18, 0, 16'd0);
        imem[26] = immInstr(opAddi, 22, 0, 16'd1);
        imem[27] = rTypeInstr(fnAdd, 18, 18, 19);
        imem[28] = immInstr(opAddi, 19, 19, -16'sd1);
        imem[29] = immInstr(opSw, 18, 10, 16'd36);
        imem[30] = rTypeInstr(fnSlt, 21, 0, 19);
        imem[31] = immInstr(opBeq, 22, 21, -16'sd5);
        imem[32] = immInstr(opBeq, 2, 1, 16'd2);
        imem[33] = jumpInstr(26'd36);
        // skipped by the jump
        imem[34] = immInstr(opSw, 1, 10, 16'd40);
        imem[35] = immInstr(opAddi, 3, 0, 16'd99);
        imem[36] = immInstr(opSw, 3, 10, 16'd44);
        imem[37] = immInstr(opBeq, 0, 0, 16'd1);
        imem[38] = immInstr(opSw, 2, 10, 16'd48);
        imem[39] = immInstr(opAddi, 23, 0, doneAddr[15:0]);
        imem[40] = immInstr(opSw, 22, 23, 16'd0);
        imem[41] = jumpInstr(26'd41);
    endtask

    // instruction level interpreter without a delay slot
    function automatic bit buildExpected();
        word_t    regs [32];
        word_t    mem [dmemDepth];
        word_t    pc;
        word_t    nextPc;
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    addr;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmemDepth; i++) begin
            mem[i] = fillWord(wordAddrWidth'(i));
        end
        pc = '0;
        for (int step = 0; step < stepLimit; step++) begin
            instr  = (pc[31:2] < imemDepth) ? imem[pc[31:2]] : '0;
            rs     = instr[rsMsb:rsLsb];
            rt     = instr[rtMsb:rtLsb];
            rd     = instr[rdMsb:rdLsb];
            a      = regs[rs];
            b      = regs[rt];
            imm    = {{16{instr[immMsb]}}, instr[immMsb:immLsb]};
            addr   = a + imm;
            nextPc = pc + 32'd4;
            case (instr[opMsb:opLsb])
                opRType: begin
                    case (instr[functMsb:functLsb])
                        fnAdd:   regs[rd] = a + b;
                        fnSub:   regs[rd] = a - b;
                        fnAnd:   regs[rd] = a & b;
                        fnOr:    regs[rd] = a | b;
                        fnSlt:   regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                opAddi: regs[rt] = addr;
                opLw: begin
                    regs[rt] = (addr[31:2] < dmemDepth) ? mem[addr[31:2]] : fillWord(addr[31:2]);
                end
                opSw: begin
                    expAddr.push_back({2'b00, addr[31:2]});
                    expData.push_back(b);
                    if (addr[31:2] < dmemDepth) begin
                        mem[addr[31:2]] = b;
                    end
                    if (addr == doneAddr) begin
                        return 1'b1;
                    end
                end
                opBeq: begin
                    if (a == b) begin
                        nextPc = nextPc + {imm[29:0], 2'b00};
                    end
                end
                opJ:     nextPc = {nextPc[31:28], instr[targetMsb:targetLsb], 2'b00};
                default: ;
            endcase
            regs[0] = '0;
            pc      = nextPc;
        end
        return 1'b0;
    endfunction

    //////////////////////////////////////////////////
    // memories, stalls and store checker
    //////////////////////////////////////////////////

    // read data is valid only for an unstalled access
    assign icacheRdata = icacheStall              ? 'x
                       : (icacheAddr < imemDepth) ? imem[icacheAddr]
                       : '0;
    assign dcacheRdata = (!dcacheRen || dcacheStall) ? 'x
                       : (dcacheAddr < dmemDepth)    ? dmem[dcacheAddr]
                       : fillWord(dcacheAddr);

    always @(posedge clk) begin
        if (dcacheWen && !dcacheStall && dcacheAddr < dmemDepth) begin
            dmem[dcacheAddr] <= dcacheWdata;
        end
    end

    // short random bursts on each cache
    always @(negedge clk) begin
        if (!stallOn) begin
            icacheStall = 1'b0;
            dcacheStall = 1'b0;
            iBurst      = 0;
            dBurst      = 0;
        end else begin
            rngState = xorshift32(rngState);
            if (iBurst > 0) begin
                icacheStall = 1'b1;
                iBurst--;
            end else if (rngState[2:0] == 3'd0) begin
                icacheStall = 1'b1;
                iBurst      = rngState[5:4];
            end else begin
                icacheStall = 1'b0;
            end
            if (dBurst > 0) begin
                dcacheStall = 1'b1;
                dBurst--;
            end else if (rngState[10:8] == 3'd0) begin
                dcacheStall = 1'b1;
                dBurst      = rngState[13:12];
            end else begin
                dcacheStall = 1'b0;
            end
        end
    end

    // a frozen pipe presents the same store again, so count it when the pipe moves
    always @(posedge clk) begin
        if (rst_n && dcacheWen && !dcacheStall && !icacheStall) begin
            if (storeCount >= expAddr.size()) begin
                stopOnError("a store appeared after the expected store sequence had ended");
            end else begin
                compareValue("dcacheAddr", {2'b00, dcacheAddr}, expAddr[storeCount]);
                compareValue("dcacheWdata", dcacheWdata, expData[storeCount]);
                storeCount++;
            end
        end
    end

    task automatic runProgram(input bit withStalls);
        int cycles;
        @(posedge clk);
        stallOn = 1'b0;
        @(negedge clk);
        rst_n      = 1'b0;
        storeCount = 0;
        for (int i = 0; i < dmemDepth; i++) begin
            dmem[i] = fillWord(wordAddrWidth'(i));
        end
        repeat (16) begin
            @(negedge clk);
            compareValue("dcacheRen", dcacheRen, '0);
            compareValue("dcacheWen", dcacheWen, '0);
            compareValue("icacheAddr", icacheAddr, '0);
        end
        rst_n = 1'b1;
        @(posedge clk);
        stallOn = withStalls;
        cycles  = 0;
        while (storeCount < expAddr.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > storeTimeout) begin
                stopOnError("timed out waiting for the program to finish its stores");
            end
        end
        // idle a while so a stray late store gets caught
        repeat (20) @(negedge clk);
        $display("run with stalls=%0b done, %0d stores matched", withStalls, storeCount);
    endtask

    initial begin
        rst_n       = 1'b0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        stallOn     = 1'b0;
        rngState    = 32'h90ee_5673;
        iBurst      = 0;
        dBurst      = 0;
        storeCount  = 0;
        errorCount  = 0;
        loadProgram();
        if (!buildExpected()) begin
            stopOnError("the reference model never reached the store to the done address");
        end
        runProgram(1'b0);
        runProgram(1'b1);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
